//--- hdl/mem_pkg.sv
// memory geometry constants for the banked data memory
// request, tag and read data types shared by decoder, wrapper and response unit

package mem_pkg;

  // cut geometry
  localparam int unsigned N_BANKS   = 8;
  localparam int unsigned BANK_W    = 3;     // log2 of N_BANKS
  localparam int unsigned CUT_WORDS = 1024;
  localparam int unsigned CUT_AW    = 10;    // word index inside one cut
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned BE_W      = 4;     // one enable per byte

  // whole memory as seen from the bus
  localparam int unsigned MEM_BYTES = 32768; // N_BANKS * CUT_WORDS * BE_W
  localparam int unsigned ADDR_W    = 32;

  // decoded request towards the SRAM array
  typedef struct packed {
    logic              en;     // in-range request, selects one cut
    logic              we;
    logic [BANK_W-1:0] bank;
    logic [CUT_AW-1:0] idx;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } mem_req_t;

  // what the response unit has to answer one cycle later
  typedef struct packed {
    logic              valid;  // any request this cycle
    logic              err;    // address outside the memory
    logic              rd;     // in-range read, read data follows
    logic [BANK_W-1:0] bank;
  } mem_tag_t;

  // every cut output, kept apart
  typedef logic [N_BANKS-1:0][DATA_W-1:0] bank_rdata_t;

endpackage

//--- hdl/sram_macro.sv
// behavioural single-port SRAM cut, 1024 words of 32 bits
// active-low select and write, per-byte write mask

`timescale 1ns/10ps

module sram_macro (
  input  logic                        clk_i,
  input  logic                        csb_i,   // select, active low
  input  logic                        web_i,   // write, active low
  input  logic [mem_pkg::BE_W-1:0]    wmask_i,
  input  logic [mem_pkg::CUT_AW-1:0]  addr_i,
  input  logic [mem_pkg::DATA_W-1:0]  din_i,
  output logic [mem_pkg::DATA_W-1:0]  dout_o
);

  logic [mem_pkg::DATA_W-1:0] mem_q [mem_pkg::CUT_WORDS];

  // one access per selected edge, write or read
  always_ff @(posedge clk_i)
  begin
    if (!csb_i)
    begin
      if (!web_i)
      begin
        for (int b = 0; b < mem_pkg::BE_W; b++)
        begin
          if (wmask_i[b])
          begin
            mem_q[addr_i][b*(mem_pkg::DATA_W/mem_pkg::BE_W) +: (mem_pkg::DATA_W/mem_pkg::BE_W)]
              <= din_i[b*(mem_pkg::DATA_W/mem_pkg::BE_W) +: (mem_pkg::DATA_W/mem_pkg::BE_W)];
          end
        end
      end
      else
      begin
        dout_o <= mem_q[addr_i];  // holds until next read
      end
    end
  end

  // a selected cut must see a clean address
  a_addr_known : assert property (@(posedge clk_i) !csb_i |-> !$isunknown(addr_i))
    else $error("sram_macro: unknown address while selected");

endmodule

//--- hdl/sram_wrapper.sv
// banked SRAM array of eight 1024x32 cuts
// one-hot chip select from the bank field, separate read data per cut

`timescale 1ns/10ps

module sram_wrapper (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  mem_pkg::mem_req_t     mem_req_i,
  output mem_pkg::bank_rdata_t  bank_rdata_o
);

  logic [mem_pkg::N_BANKS-1:0] cs;

  // at most one cut per request
  always_comb
  begin
    cs = '0;
    cs[mem_req_i.bank] = mem_req_i.en;
  end

  for (genvar g = 0; g < mem_pkg::N_BANKS; g++)
  begin : g_cut
    sram_macro u_cut (
      .clk_i   (clk_i),
      .csb_i   (~cs[g]),
      .web_i   (~mem_req_i.we),
      .wmask_i (mem_req_i.be),
      .addr_i  (mem_req_i.idx),
      .din_i   (mem_req_i.wdata),
      .dout_o  (bank_rdata_o[g])   // not shorted, response unit picks one
    );
  end

  // an unknown bank would leave every cut deselected
  a_bank_known : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_i.en |-> !$isunknown(mem_req_i.bank))
    else $error("sram_wrapper: unknown bank on an enabled request");

endmodule

//--- hdl/mem_req_decode.sv
// request decoder, range check and address split into bank and word index
// also builds the tag for the response unit

`timescale 1ns/10ps

module mem_req_decode (
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [mem_pkg::ADDR_W-1:0]  addr_i,
  input  logic [mem_pkg::DATA_W-1:0]  wdata_i,
  input  logic [mem_pkg::BE_W-1:0]    be_i,
  output mem_pkg::mem_req_t           mem_req_o,
  output mem_pkg::mem_tag_t           tag_o
);

  logic in_range;

  always_comb
  begin
    in_range = (addr_i < mem_pkg::MEM_BYTES);

    // low byte-offset bits are dropped, accesses are word aligned
    mem_req_o.en    = req_i & in_range;
    mem_req_o.we    = we_i;
    mem_req_o.bank  = addr_i[$clog2(mem_pkg::BE_W) + mem_pkg::CUT_AW +: mem_pkg::BANK_W];
    mem_req_o.idx   = addr_i[$clog2(mem_pkg::BE_W) +: mem_pkg::CUT_AW];
    mem_req_o.wdata = wdata_i;
    mem_req_o.be    = be_i;

    tag_o.valid = req_i;
    tag_o.err   = req_i & ~in_range;
    tag_o.rd    = req_i & in_range & ~we_i;  // only these move read data
    tag_o.bank  = mem_req_o.bank;
  end

endmodule

//--- hdl/mem_rsp_unit.sv
// response unit, registered valid and error pulses
// read data mux over the cut outputs, bank captured on in-range reads

`timescale 1ns/10ps

module mem_rsp_unit (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  mem_pkg::mem_tag_t           tag_i,
  input  mem_pkg::bank_rdata_t        bank_rdata_i,
  output logic                        rvalid_o,
  output logic                        err_o,
  output logic [mem_pkg::DATA_W-1:0]  rdata_o
);

  logic [mem_pkg::BANK_W-1:0] bank_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
      bank_q   <= '0;
    end
    else
    begin
      rvalid_o <= tag_i.valid;  // one pulse per request
      err_o    <= tag_i.err;
      // writes and errors keep the last read bank
      if (tag_i.rd)
      begin
        bank_q <= tag_i.bank;
      end
    end
  end

  // cut outputs hold between reads, so the mux output holds too
  assign rdata_o = bank_rdata_i[bank_q];

  a_err_with_valid : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    err_o |-> rvalid_o)
    else $error("mem_rsp_unit: err_o without rvalid_o");

  // read data only moves after an in-range read, across the whole array
  a_rdata_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$past(tag_i.rd) |-> (rdata_o === $past(rdata_o)))
    else $error("mem_rsp_unit: rdata_o changed without a read");

endmodule

//--- hdl/mem_subsys.sv
// data memory subsystem top
// decoder, banked SRAM array and response unit on one request port

`timescale 1ns/10ps

module mem_subsys (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [mem_pkg::ADDR_W-1:0]  addr_i,
  input  logic [mem_pkg::DATA_W-1:0]  wdata_i,
  input  logic [mem_pkg::BE_W-1:0]    be_i,
  output logic                        rvalid_o,
  output logic                        err_o,
  output logic [mem_pkg::DATA_W-1:0]  rdata_o
);

  mem_pkg::mem_req_t     mem_req;
  mem_pkg::mem_tag_t     tag;
  mem_pkg::bank_rdata_t  bank_rdata;

  mem_req_decode u_mem_req_decode (
    .req_i     (req_i),
    .we_i      (we_i),
    .addr_i    (addr_i),
    .wdata_i   (wdata_i),
    .be_i      (be_i),
    .mem_req_o (mem_req),
    .tag_o     (tag)
  );

  sram_wrapper u_sram_wrapper (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .mem_req_i    (mem_req),
    .bank_rdata_o (bank_rdata)
  );

  mem_rsp_unit u_mem_rsp_unit (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .tag_i        (tag),
    .bank_rdata_i (bank_rdata),
    .rvalid_o     (rvalid_o),
    .err_o        (err_o),
    .rdata_o      (rdata_o)
  );

endmodule

//--- verif/mem_subsys_tb.sv
// directed testbench for the data memory subsystem
// clock, reset, watchdog, word reference model, compare task and tests

`timescale 1ns/10ps

module mem_subsys_tb;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  // request slots of idle, full word, byte mask, back to back and range tests
  localparam int TOTAL_STEPS  = 10 + 17 + 13 + 65 + 9;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + TOTAL_STEPS) * CLK_PERIOD + 100;

  logic                        clk_i;
  logic                        arst_n_i;
  logic                        req_i;
  logic                        we_i;
  logic [mem_pkg::ADDR_W-1:0]  addr_i;
  logic [mem_pkg::DATA_W-1:0]  wdata_i;
  logic [mem_pkg::BE_W-1:0]    be_i;
  logic                        rvalid_o;
  logic                        err_o;
  logic [mem_pkg::DATA_W-1:0]  rdata_o;

  logic [31:0] model [int unsigned];  // word address to stored word
  int unsigned written_q [$];         // word addresses known to hold data
  logic        exp_valid;
  logic        exp_err;
  logic        exp_rd;
  logic [31:0] exp_word;
  logic [31:0] last_rdata;
  logic        rdata_known;
  string       cur_test;
  integer      seed;
  int          errors;
  int          tests_passed;
  int          tests_failed;

  mem_subsys u_mem_subsys (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .be_i     (be_i),
    .rvalid_o (rvalid_o),
    .err_o    (err_o),
    .rdata_o  (rdata_o)
  );

  always
  begin
    #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  // response of the previous slot, outputs stable at the falling edge
  task automatic check_response();
    compare("rvalid", 32'(exp_valid), 32'(rvalid_o));
    compare("err", 32'(exp_err), 32'(err_o));
    if (exp_rd)
    begin
      last_rdata  = exp_word;
      rdata_known = 1'b1;
    end
    if (rdata_known)
      compare("rdata", last_rdata, rdata_o);  // holds through writes and errors
  endtask

  // one request slot: check last response, then drive and predict
  task automatic step(input logic req, input logic we, input logic [31:0] addr,
                      input logic [31:0] wdata, input logic [3:0] be);
    int unsigned key;
    logic [31:0] merged;
    @(negedge clk_i);
    check_response();
    key       = addr[14:2];
    exp_valid = req;
    exp_err   = req && (addr[31:15] != '0);
    exp_rd    = req && !we && !exp_err;
    if (exp_rd)
      exp_word = model.exists(key) ? model[key] : 'x;
    if (req && we && !exp_err)
    begin
      merged = model.exists(key) ? model[key] : 'x;
      for (int b = 0; b < 4; b++)
      begin
        if (be[b])
          merged[8*b +: 8] = wdata[8*b +: 8];
      end
      if (!model.exists(key))
        written_q.push_back(key);
      model[key] = merged;
    end
    req_i   = req;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    be_i    = be;
  endtask

  task automatic report_test(input int errs_before);
    if (errors == errs_before)
    begin
      tests_passed++;
      $display("test %s passed", cur_test);
    end
    else
    begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, errors - errs_before);
    end
  endtask

  task automatic test_idle();
    int errs_before;
    errs_before = errors;
    cur_test    = "idle";
    repeat (10) step(1'b0, 1'b0, '0, '0, '0);
    report_test(errs_before);
  endtask

  task automatic test_full_word();
    int errs_before;
    logic [31:0] addrs [8];
    errs_before = errors;
    cur_test    = "full_word";
    for (int bank = 0; bank < 8; bank++)
    begin
      addrs[bank] = (32'(bank) << 12) | ((32'($random(seed)) & 32'h3ff) << 2);
      step(1'b1, 1'b1, addrs[bank], 32'($random(seed)), 4'hf);
    end
    for (int bank = 0; bank < 8; bank++)
      step(1'b1, 1'b0, addrs[bank], '0, '0);
    step(1'b0, 1'b0, '0, '0, '0);  // collect last read
    report_test(errs_before);
  endtask

  task automatic test_byte_mask();
    int errs_before;
    errs_before = errors;
    cur_test    = "byte_mask";
    step(1'b1, 1'b1, 32'h0000_5a3c, 32'h1122_3344, 4'hf);
    step(1'b1, 1'b0, 32'h0000_5a3c, '0, '0);
    for (int b = 0; b < 4; b++)
    begin
      step(1'b1, 1'b1, 32'h0000_5a3c, 32'($random(seed)), 4'(1 << b));
      step(1'b1, 1'b0, 32'h0000_5a3c, '0, '0);
    end
    step(1'b1, 1'b1, 32'h0000_5a3c, 32'hdead_beef, 4'b0110);
    step(1'b1, 1'b0, 32'h0000_5a3c, '0, '0);
    step(1'b0, 1'b0, '0, '0, '0);
    report_test(errs_before);
  endtask

  task automatic test_back_to_back();
    int errs_before;
    logic        do_write;
    logic [31:0] addr;
    logic [3:0]  be;
    errs_before = errors;
    cur_test    = "back_to_back";
    for (int i = 0; i < 64; i++)
    begin
      do_write = (written_q.size() == 0) || (($random(seed) & 1) != 0);
      if (!do_write || (($random(seed) & 3) == 0))
        addr = written_q[$unsigned($random(seed)) % written_q.size()] << 2;
      else
        addr = 32'($random(seed)) & 32'h7ffc;
      be = model.exists(addr[14:2]) ? 4'($random(seed)) : 4'hf;  // new words written full
      step(1'b1, do_write, addr, 32'($random(seed)), be);
    end
    step(1'b0, 1'b0, '0, '0, '0);
    report_test(errs_before);
  endtask

  task automatic test_out_of_range();
    int errs_before;
    errs_before = errors;
    cur_test    = "out_of_range";
    step(1'b1, 1'b1, 32'h0000_1234, 32'hcafe_f00d, 4'hf);
    step(1'b1, 1'b0, 32'h0000_1234, '0, '0);
    step(1'b1, 1'b1, 32'h0000_9234, 32'h0bad_0bad, 4'hf);  // aliases 0x1234
    step(1'b1, 1'b0, 32'h8000_1234, '0, '0);
    step(1'b1, 1'b1, 32'h0000_7ff8, 32'h5a5a_a5a5, 4'hf);
    step(1'b1, 1'b1, 32'h0001_1234, 32'h0bad_cafe, 4'hf);
    step(1'b1, 1'b0, 32'h0000_1234, '0, '0);               // still the first word
    step(1'b1, 1'b0, 32'h0000_7ff8, '0, '0);
    step(1'b0, 1'b0, '0, '0, '0);
    report_test(errs_before);
  endtask

  initial
  begin
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    be_i        = '0;
    exp_valid   = 1'b0;
    exp_err     = 1'b0;
    exp_rd      = 1'b0;
    exp_word    = '0;
    last_rdata  = '0;
    rdata_known = 1'b0;
    seed        = 61447;
    errors      = 0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    arst_n_i = 1'b1;
    test_idle();
    test_full_word();
    test_byte_mask();
    test_back_to_back();
    test_out_of_range();
    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // watchdog sized from the request slots of all tests
  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: tests still running after %0d ns", TIMEOUT_NS);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- all.f
hdl/mem_pkg.sv
hdl/sram_macro.sv
hdl/sram_wrapper.sv
hdl/mem_req_decode.sv
hdl/mem_rsp_unit.sv
hdl/mem_subsys.sv
verif/mem_subsys_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mem_subsys_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(BUILD_DIR)
